//--- dv/tb_spi_regs.sv
`timescale 1ns/10ps

module tb_spi_regs;
  import spi_pkg::*;

  localparam int CLK_PERIOD   = 4;  // ns
  localparam int RESET_CYCLES = 8;
  localparam int HALF_SCLK    = 8;  // clk cycles per sclk half period
  localparam int LEAD_CYCLES  = 8;  // cs low to first rising sclk
  localparam int TAIL_CYCLES  = 6;  // last falling sclk to cs high
  localparam int GAP_CYCLES   = 8;  // cs high between frames
  localparam int NUM_FRAMES   = 27;
  localparam int NUM_BYTES    = 62;  // command bytes included
  localparam int FRAME_CYCLES = LEAD_CYCLES + TAIL_CYCLES + GAP_CYCLES;
  localparam int TEST_CYCLES  = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES
                                + NUM_BYTES * 2 * HALF_SCLK * 8 + 32;
  localparam spi_byte_t ID_VALUE = 8'hA5;

  logic        rst;  // clock
  logic        clk;  // reset, active high
  logic        sclk;
  logic        mosi;
  logic        cs;
  logic        miso;
  spi_byte_t   gpio_in;
  spi_byte_t   gpio_out;

  logic [15:0] lfsr;
  spi_byte_t   reg_model [8];     // expected register contents
  spi_byte_t   echo_model;        // last data byte sent in any frame
  spi_byte_t   last_echo;         // miso during the latest command byte
  spi_byte_t   gpio_at_cs_rise;
  spi_byte_t   mosi_bytes [8];
  spi_byte_t   miso_bytes [8];
  string       cur_test;
  int          checks;
  int          errors;
  int          test_errors_start;
  int          tests_run;

  spi_regs_top uut (
    .rst      (rst),
    .clk      (clk),
    .sclk     (sclk),
    .mosi     (mosi),
    .cs       (cs),
    .miso     (miso),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

  initial rst = 1'b0;
  always #(CLK_PERIOD / 2) rst = ~rst;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // inputs change 1 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge rst);
    #1;
  endtask

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] nxt;
    nxt = s >> 1;
    if (s[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  function automatic spi_byte_t next_rand_byte();
    spi_byte_t b;
    int        i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_step(lfsr);
    end
    return b;
  endfunction

  task automatic fill_mosi(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      mosi_bytes[i] = next_rand_byte();
    end
  endtask

  // addresses 8 and up read zero
  function automatic spi_byte_t model_read(input cmd_addr_t a);
    if (a < 7'd8) begin
      return reg_model[a[2:0]];
    end
    return '0;
  endfunction

  // 0 and 3 are read only, 8 and up ignore writes
  function automatic void model_write(input cmd_addr_t a, input spi_byte_t d);
    if (a < 7'd8 && a != 7'd0 && a != 7'd3) begin
      reg_model[a[2:0]] = d;
    end
  endfunction

  task automatic check_byte(input string what, input spi_byte_t exp, input spi_byte_t act);
    checks++;
    assert (act === exp) else begin
      $display("Error: test %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    test_errors_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - test_errors_start);
    end
  endtask

  //////////////////////////////
  // spi master, mode 1
  //////////////////////////////

  task automatic xfer_byte(input spi_byte_t tx, output spi_byte_t rx);
    int i;
    rx = '0;
    for (i = 7; i >= 0; i--) begin
      sclk = 1'b1;
      mosi = tx[i];  // master shifts out on the rising edge
      wait_cycles(HALF_SCLK);
      rx[i] = miso;  // sampled at the falling edge
      sclk  = 1'b0;
      wait_cycles(HALF_SCLK);
    end
  endtask

  // command byte, then n data bytes from mosi_bytes
  task automatic run_frame(input logic wr, input cmd_addr_t addr, input int n);
    spi_byte_t cmd;
    spi_byte_t rx;
    cmd_addr_t a;
    int        i;
    cmd = {wr, addr};
    a   = addr;
    cs  = 1'b0;
    wait_cycles(LEAD_CYCLES);
    xfer_byte(cmd, last_echo);
    check_byte("command echo", echo_model, last_echo);
    for (i = 0; i < n; i++) begin
      xfer_byte(mosi_bytes[i], rx);
      miso_bytes[i] = rx;
      if (wr) begin
        model_write(a, mosi_bytes[i]);
      end else begin
        check_byte("read data", model_read(a), rx);
      end
      echo_model = mosi_bytes[i];
      a          = a + 7'd1;
    end
    wait_cycles(TAIL_CYCLES);
    gpio_at_cs_rise = gpio_out;
    cs              = 1'b1;
    wait_cycles(GAP_CYCLES);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_state();
    begin_test("reset_state");
    check_byte("miso after reset", 8'h00, {7'd0, miso});
    check_byte("gpio_out after reset", 8'h00, gpio_out);
    run_frame(1'b0, 7'd0, 0);
    check_byte("first echo", 8'h00, last_echo);
    end_test();
  endtask

  task automatic test_id_and_range();
    begin_test("id_and_range");
    fill_mosi(1);
    run_frame(1'b0, 7'd0, 1);
    check_byte("id register", ID_VALUE, miso_bytes[0]);
    fill_mosi(2);
    run_frame(1'b0, 7'd8, 2);
    check_byte("address 8", 8'h00, miso_bytes[0]);
    check_byte("address 9", 8'h00, miso_bytes[1]);
    fill_mosi(2);
    run_frame(1'b0, 7'h7E, 2);
    check_byte("address 7e", 8'h00, miso_bytes[0]);
    check_byte("address 7f", 8'h00, miso_bytes[1]);
    end_test();
  endtask

  // read data is compared with the model inside run_frame
  task automatic test_scratch_single();
    int i;
    begin_test("scratch_single");
    for (i = 1; i < 8; i++) begin
      if (i != 2 && i != 3) begin
        fill_mosi(1);
        run_frame(1'b1, cmd_addr_t'(i), 1);
      end
    end
    for (i = 1; i < 8; i++) begin
      if (i != 2 && i != 3) begin
        fill_mosi(1);
        run_frame(1'b0, cmd_addr_t'(i), 1);
      end
    end
    end_test();
  endtask

  task automatic test_burst();
    spi_byte_t burst [4];
    int        i;
    begin_test("burst");
    fill_mosi(4);
    for (i = 0; i < 4; i++) begin
      burst[i] = mosi_bytes[i];
    end
    run_frame(1'b1, 7'd4, 4);
    fill_mosi(4);
    run_frame(1'b0, 7'd4, 4);
    for (i = 0; i < 4; i++) begin
      check_byte("burst readback", burst[i], miso_bytes[i]);
    end
    end_test();
  endtask

  task automatic test_gpio();
    spi_byte_t v;
    spi_byte_t pins;
    begin_test("gpio");
    fill_mosi(1);
    v = mosi_bytes[0];
    run_frame(1'b1, 7'd2, 1);
    check_byte("gpio_out at cs rise", v, gpio_at_cs_rise);
    fill_mosi(1);
    run_frame(1'b0, 7'd2, 1);
    pins         = next_rand_byte();
    gpio_in      = pins;
    reg_model[3] = pins;
    wait_cycles(4);  // pin register settles
    fill_mosi(1);
    run_frame(1'b0, 7'd3, 1);
    check_byte("gpio_in readback", pins, miso_bytes[0]);
    fill_mosi(1);
    run_frame(1'b1, 7'd0, 1);
    fill_mosi(1);
    run_frame(1'b1, 7'd3, 1);
    fill_mosi(4);
    run_frame(1'b0, 7'd0, 4);
    check_byte("id after write", ID_VALUE, miso_bytes[0]);
    check_byte("gpio_in after write", pins, miso_bytes[3]);
    end_test();
  endtask

  task automatic test_echo();
    spi_byte_t sent;
    begin_test("echo");
    fill_mosi(1);
    sent = mosi_bytes[0];
    run_frame(1'b0, 7'd1, 1);
    run_frame(1'b0, 7'd0, 0);
    check_byte("echo after read frame", sent, last_echo);
    fill_mosi(1);
    sent = mosi_bytes[0];
    run_frame(1'b1, 7'd5, 1);
    fill_mosi(1);
    run_frame(1'b0, 7'd5, 1);
    check_byte("echo after write frame", sent, last_echo);
    sent = mosi_bytes[0];  // dummy byte of that read
    run_frame(1'b1, 7'd6, 0);
    check_byte("echo after second read frame", sent, last_echo);
    end_test();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    clk          = 1'b1;
    sclk         = 1'b0;
    mosi         = 1'b0;
    cs           = 1'b1;
    gpio_in      = '0;
    lfsr         = 16'd58;
    reg_model[0] = ID_VALUE;
    reg_model[2] = '0;  // gpio_out after reset
    reg_model[3] = '0;
    echo_model   = '0;
    checks       = 0;
    errors       = 0;
    tests_run    = 0;
    wait_cycles(RESET_CYCLES);
    clk = 1'b0;
    wait_cycles(2);
    test_reset_state();
    test_id_and_range();
    test_scratch_single();
    test_burst();
    test_gpio();
    test_echo();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // twice the expected run length
  initial begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("watchdog: the run timed out after %0d clock cycles", TEST_CYCLES * 2);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_byte_if.sv
hdl/spi_bus_if.sv
hdl/spi_slave_driver.sv
hdl/spi_frame_decoder.sv
hdl/spi_reg_file.sv
hdl/spi_regs_top.sv
dv/tb_spi_regs.sv

//--- hdl/spi_bus_if.sv
`timescale 1ns/10ps

// register access from the frame decoder into the register bank
interface spi_bus_if;
  import spi_pkg::*;

  cmd_addr_t addr;     // full 7-bit address, upper range reads zero
  logic      wr_en;    // single cycle write strobe
  spi_byte_t wr_data;
  spi_byte_t rd_data;  // combinational from addr

  modport requester (
    output addr,
    output wr_en,
    output wr_data,
    input  rd_data
  );

  modport target (
    input  addr,
    input  wr_en,
    input  wr_data,
    output rd_data
  );

endinterface

//--- hdl/spi_byte_if.sv
`timescale 1ns/10ps

// byte traffic between the shift engine and the frame decoder
interface spi_byte_if;
  import spi_pkg::*;

  spi_byte_t tx_byte;     // next byte to shift out on miso
  spi_byte_t rx_byte;     // byte just shifted in from mosi
  logic      byte_valid;  // one cycle per received byte
  logic      frame_idle;  // cs high or no sclk yet in this frame

  modport engine (
    input  tx_byte,
    output rx_byte,
    output byte_valid,
    output frame_idle
  );

  modport framer (
    output tx_byte,
    input  rx_byte,
    input  byte_valid,
    input  frame_idle
  );

endinterface

//--- hdl/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// bits per byte on the spi wire
`define SPI_DATA_WIDTH 8

// size of the register bank
`define SPI_REG_COUNT 8

// index width into the bank
`define SPI_REG_AWIDTH 3

// fixed content of register 0
`define SPI_REGS_ID 8'hA5

`endif

//--- hdl/spi_frame_decoder.sv
`timescale 1ns/10ps
`include "spi_defines.svh"

module spi_frame_decoder (
  input  logic         rst,
  input  logic         clk,
  spi_byte_if.framer   bytes,
  spi_bus_if.requester bus
);
  import spi_pkg::*;

  frame_state_e phase;
  logic         is_write;   // latched from the command msb
  cmd_addr_t    addr_q;     // running address
  spi_byte_t    echo_byte;  // last data byte of the frame
  logic         cmd_done;
  logic         data_done;

  assign cmd_done  = bytes.byte_valid && (phase == command);
  assign data_done = bytes.byte_valid && (phase == data);

  //////////////////////////////
  // frame phase and direction
  //////////////////////////////

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      phase    <= command;
      is_write <= 1'b0;
    end else if (bytes.frame_idle) begin
      phase <= command;  // every frame opens with a command byte
    end else if (cmd_done) begin
      phase    <= data;
      is_write <= bytes.rx_byte[`SPI_DATA_WIDTH-1];
    end
  end

  //////////////////////////////
  // address and echo tracking
  //////////////////////////////

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      addr_q    <= '0;
      echo_byte <= '0;
    end else begin
      if (cmd_done) begin
        addr_q <= bytes.rx_byte[`SPI_DATA_WIDTH-2:0];  // start address
      end else if (data_done) begin
        addr_q    <= addr_q + 1'b1;  // wraps at 127
        echo_byte <= bytes.rx_byte;
      end
    end
  end

  //////////////////////////////
  // register bus requests
  //////////////////////////////

  // bypass the fresh command address so the first read byte is ready early
  assign bus.addr    = cmd_done ? bytes.rx_byte[`SPI_DATA_WIDTH-2:0] : addr_q;
  assign bus.wr_en   = data_done && is_write;
  assign bus.wr_data = bytes.rx_byte;

  // the command byte shifts out the echo, data bytes shift out register content
  always_comb begin
    if (phase == command && !cmd_done) begin
      bytes.tx_byte = echo_byte;
    end else begin
      bytes.tx_byte = bus.rd_data;
    end
  end

  // writes only come from data bytes inside an open frame
  assert property (@(posedge rst) disable iff (clk) bus.wr_en |-> !bytes.frame_idle);

endmodule

//--- hdl/spi_pkg.sv
`include "spi_defines.svh"

package spi_pkg;

  // one byte as it travels over mosi/miso
  typedef logic [`SPI_DATA_WIDTH-1:0] spi_byte_t;

  // low bits of the command byte, also used as the running address
  typedef logic [`SPI_DATA_WIDTH-2:0] cmd_addr_t;

  // shift engine states
  typedef enum logic [1:0] {
    idle,            // cs high, waiting for a frame
    wait_sclk_high,  // next rising sclk drives miso
    wait_sclk_low,   // next falling sclk samples mosi
    reload           // byte done, fetch the next tx byte
  } drv_state_e;

  // frame decoder phase
  typedef enum logic {
    command,  // first byte of the frame
    data      // every byte after the command
  } frame_state_e;

endpackage

//--- hdl/spi_reg_file.sv
`timescale 1ns/10ps
`include "spi_defines.svh"

module spi_reg_file (
  input  logic               rst,
  input  logic               clk,
  spi_bus_if.target          bus,
  input  spi_pkg::spi_byte_t gpio_in,
  output spi_pkg::spi_byte_t gpio_out
);
  import spi_pkg::*;

  localparam logic [`SPI_REG_AWIDTH-1:0] ID_IDX       = `SPI_REG_AWIDTH'(0);
  localparam logic [`SPI_REG_AWIDTH-1:0] GPIO_OUT_IDX = `SPI_REG_AWIDTH'(2);
  localparam logic [`SPI_REG_AWIDTH-1:0] GPIO_IN_IDX  = `SPI_REG_AWIDTH'(3);

  logic [`SPI_REG_AWIDTH-1:0] idx;
  logic                       in_range;
  logic                       read_only;
  logic                       gpio_we;
  logic                       scratch_we;
  spi_byte_t                  scratch [`SPI_REG_COUNT];  // 1 and 4..7 in use
  spi_byte_t                  gpio_in_q;

  //////////////////////////////
  // address decode
  //////////////////////////////

  assign idx        = bus.addr[`SPI_REG_AWIDTH-1:0];
  assign in_range   = bus.addr < cmd_addr_t'(`SPI_REG_COUNT);
  assign read_only  = (idx == ID_IDX) || (idx == GPIO_IN_IDX);
  assign gpio_we    = bus.wr_en && in_range && (idx == GPIO_OUT_IDX);
  assign scratch_we = bus.wr_en && in_range && !read_only && (idx != GPIO_OUT_IDX);

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      gpio_out <= '0;
    end else if (gpio_we) begin
      gpio_out <= bus.wr_data;
    end
  end

  always_ff @(posedge rst) begin
    if (scratch_we) begin
      scratch[idx] <= bus.wr_data;
    end
  end

  // one flop on the pins before the value can reach miso
  always_ff @(posedge rst) begin
    gpio_in_q <= gpio_in;
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  always_comb begin
    bus.rd_data = '0;  // addresses 8 and up
    if (in_range) begin
      case (idx)
        ID_IDX:       bus.rd_data = `SPI_REGS_ID;
        GPIO_OUT_IDX: bus.rd_data = gpio_out;
        GPIO_IN_IDX:  bus.rd_data = gpio_in_q;
        default:      bus.rd_data = scratch[idx];
      endcase
    end
  end

  // the decoder must never strobe a write before its address settles
  assert property (@(posedge rst) disable iff (clk) bus.wr_en |-> !$isunknown(bus.addr));

endmodule

//--- hdl/spi_regs_top.sv
`timescale 1ns/10ps

module spi_regs_top (
  input  logic               rst,
  input  logic               clk,
  input  logic               sclk,
  input  logic               mosi,
  input  logic               cs,
  output logic               miso,
  input  spi_pkg::spi_byte_t gpio_in,
  output spi_pkg::spi_byte_t gpio_out
);

  // byte stream between shifter and decoder
  spi_byte_if byte_if ();

  // register accesses between decoder and bank
  spi_bus_if bus_if ();

  spi_slave_driver u_driver (
    .rst  (rst),
    .clk  (clk),
    .sclk (sclk),
    .mosi (mosi),
    .cs   (cs),
    .miso (miso),
    .bus  (byte_if.engine)
  );

  spi_frame_decoder u_decoder (
    .rst   (rst),
    .clk   (clk),
    .bytes (byte_if.framer),
    .bus   (bus_if.requester)
  );

  spi_reg_file u_regs (
    .rst      (rst),
    .clk      (clk),
    .bus      (bus_if.target),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out)
  );

endmodule

//--- hdl/spi_slave_driver.sv
`timescale 1ns/10ps
`include "spi_defines.svh"

module spi_slave_driver (
  input  logic       rst,
  input  logic       clk,
  input  logic       sclk,
  input  logic       mosi,
  input  logic       cs,
  output logic       miso,
  spi_byte_if.engine bus
);
  import spi_pkg::*;

  localparam int CNT_W = $clog2(`SPI_DATA_WIDTH + 1);

  logic [1:0]       sclk_sync;
  logic [1:0]       mosi_sync;
  logic [1:0]       cs_sync;
  logic             sclk_s;
  logic             mosi_s;
  logic             cs_s;
  spi_byte_t        shift_reg;
  logic [CNT_W-1:0] bit_cnt;
  drv_state_e       state;

  //////////////////////////////
  // pin synchronizers
  //////////////////////////////

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      cs_sync   <= 2'b11;  // cs idles high
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      cs_sync   <= {cs_sync[0], cs};
    end
  end

  assign sclk_s = sclk_sync[1];
  assign mosi_s = mosi_sync[1];
  assign cs_s   = cs_sync[1];

  //////////////////////////////
  // mode 1 shift engine
  //////////////////////////////

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state          <= idle;
      bit_cnt        <= '0;
      miso           <= 1'b0;
      bus.byte_valid <= 1'b0;
      bus.frame_idle <= 1'b1;
    end else begin
      bus.byte_valid <= 1'b0;
      if (cs_s) begin
        state          <= idle;
        bit_cnt        <= '0;
        bus.frame_idle <= 1'b1;
      end else begin
        case (state)
          idle: begin
            bit_cnt <= '0;
            state   <= wait_sclk_high;
          end
          wait_sclk_high: if (sclk_s) begin
            miso           <= shift_reg[`SPI_DATA_WIDTH-1];  // msb first
            bus.frame_idle <= 1'b0;
            state          <= wait_sclk_low;
          end
          wait_sclk_low: if (!sclk_s) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(`SPI_DATA_WIDTH - 1)) begin
              bus.byte_valid <= 1'b1;
              state          <= reload;
            end else begin
              state <= wait_sclk_high;
            end
          end
          reload: if (!bus.byte_valid) begin  // let the decoder settle tx_byte first
            bit_cnt <= '0;
            state   <= wait_sclk_high;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // data path of the shifter
  always_ff @(posedge rst) begin
    if (!cs_s) begin
      case (state)
        idle:          shift_reg <= bus.tx_byte;
        wait_sclk_low: if (!sclk_s) shift_reg <= {shift_reg[`SPI_DATA_WIDTH-2:0], mosi_s};
        reload:        if (!bus.byte_valid) shift_reg <= bus.tx_byte;
        default:       shift_reg <= shift_reg;
      endcase
    end
  end

  assign bus.rx_byte = shift_reg;  // full byte while byte_valid is high

  // a byte takes at least eight sclk periods, so strobes never touch
  assert property (@(posedge rst) disable iff (clk) bus.byte_valid |=> !bus.byte_valid);

  assert property (@(posedge rst) disable iff (clk) bit_cnt <= CNT_W'(`SPI_DATA_WIDTH));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_spi_regs -f files.f \
  || { echo "run.sh: verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_spi_regs)
echo "$out"

echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
